//--- hdl/av_out_settings.svh
////////////////////////////////////////
// av output stage geometry
// frame size, sync point and i2s divider
////////////////////////////////////////

`ifndef AV_OUT_SETTINGS_SVH
`define AV_OUT_SETTINGS_SVH

////////////////////////////////////////
// raster geometry, in clocks and lines
////////////////////////////////////////

// cycles per line, visible part and its start
`define AV_H_TOTAL      320
`define AV_H_ACTIVE     256
`define AV_H_BPORCH     10

// lines per frame, visible part and its start
`define AV_V_TOTAL      960
`define AV_V_ACTIVE     240
`define AV_V_BPORCH     10

// hs lands a few cycles after vs
`define AV_HS_OFFSET    3

////////////////////////////////////////
// i2s framing
////////////////////////////////////////

// mclk cycles per sclk period
`define AV_I2S_MCLK_DIV     4
// sclk cycles per channel slot
`define AV_I2S_SLOT_BITS    32

`endif

//--- hdl/video_timing_pkg.sv
////////////////////////////////////////
// video timing types
// raster position, pixel colour, video bundle
////////////////////////////////////////

`include "av_out_settings.svh"

package video_timing_pkg;

    // counter width, wide enough for the line count
    localparam int pos_w = $clog2(`AV_V_TOTAL);

    // position inside the full frame, border included
    typedef struct packed {
        logic [pos_w-1:0] x;
        logic [pos_w-1:0] y;
    } raster_pos_t;

    // 12-bit colour from the core, 4 bits per channel
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } pixel_rgb12_t;

    ////////////////////////////////////////
    // scaler side
    ////////////////////////////////////////

    // rgb is 8/8/8, de marks the visible window
    typedef struct packed {
        logic [23:0] rgb;
        logic        de;
        logic        vs;
        logic        hs;
    } video_out_t;

endpackage

//--- hdl/i2s_pkg.sv
////////////////////////////////////////
// i2s types
// output lines and divider counts
////////////////////////////////////////

`include "av_out_settings.svh"

package i2s_pkg;

    // the three i2s lines to the dac
    typedef struct packed {
        logic sclk;
        logic lrck;
        logic dac;
    } i2s_out_t;

    // mclk to sclk divider, msb is sclk
    typedef logic [$clog2(`AV_I2S_MCLK_DIV)-1:0] mclk_div_t;

    // bit position inside one channel slot
    typedef logic [$clog2(`AV_I2S_SLOT_BITS)-1:0] slot_cnt_t;

endpackage

//--- hdl/raster_timer.sv
////////////////////////////////////////
// raster timer
// sweeps x and y over the whole frame
////////////////////////////////////////

`timescale 1ns/1ps

`include "av_out_settings.svh"

module raster_timer (
    input  logic                        audgen_mclk,
    input  logic                        reset_n,
    output video_timing_pkg::raster_pos_t pos
);

    import video_timing_pkg::*;

    ////////////////////////////////////////
    // counters
    ////////////////////////////////////////

    logic [pos_w-1:0] x_q;
    logic [pos_w-1:0] y_q;
    logic             line_end;
    logic             frame_end;

    // last cycle of a line
    assign line_end = (x_q == pos_w'(`AV_H_TOTAL - 1));

    // last line of the frame
    assign frame_end = (y_q == pos_w'(`AV_V_TOTAL - 1));

    // x runs every cycle
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            x_q <= '0;
        end else if (line_end) begin
            x_q <= '0;
        end else begin
            x_q <= x_q + 1'b1;
        end
    end

    // y steps once per line wrap
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            y_q <= '0;
        end else if (line_end) begin
            if (frame_end) begin
                y_q <= '0;
            end else begin
                y_q <= y_q + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // output
    ////////////////////////////////////////

    // border included, the video stage cuts the window
    always_comb begin
        pos.x = x_q;
        pos.y = y_q;
    end

endmodule

//--- hdl/video_out_stage.sv
////////////////////////////////////////
// video output stage
// decodes raster position into de/hs/vs
// and registers the pixel into 24-bit rgb
////////////////////////////////////////

`timescale 1ns/1ps

`include "av_out_settings.svh"

module video_out_stage (
    input  logic                          audgen_mclk,
    input  logic                          reset_n,
    input  video_timing_pkg::raster_pos_t  pos,
    input  video_timing_pkg::pixel_rgb12_t pixel,
    output video_timing_pkg::video_out_t   video
);

    import video_timing_pkg::*;

    ////////////////////////////////////////
    // position decode
    ////////////////////////////////////////

    logic         h_active;
    logic         v_active;
    logic         in_window;
    logic         frame_start;
    logic         line_sync;
    pixel_rgb12_t pixel_q;
    logic [23:0]  rgb_wide;

    // visible columns of the line
    assign h_active = (pos.x >= pos_w'(`AV_H_BPORCH)) &&
                      (pos.x <  pos_w'(`AV_H_BPORCH + `AV_H_ACTIVE));

    // visible lines of the frame
    assign v_active = (pos.y >= pos_w'(`AV_V_BPORCH)) &&
                      (pos.y <  pos_w'(`AV_V_BPORCH + `AV_V_ACTIVE));

    assign in_window = h_active && v_active;

    // new frame at the top left corner
    assign frame_start = (pos.x == '0) && (pos.y == '0);

    // new line, kept off the vs cycle
    assign line_sync = (pos.x == pos_w'(`AV_HS_OFFSET));

    ////////////////////////////////////////
    // pixel path
    ////////////////////////////////////////

    // capture every cycle, no flow control on the feed
    always_ff @(posedge audgen_mclk) begin
        pixel_q <= pixel;
    end

    // each nibble goes to the top of its byte
    assign rgb_wide = {pixel_q.r, 4'h0, pixel_q.g, 4'h0, pixel_q.b, 4'h0};

    ////////////////////////////////////////
    // output register
    ////////////////////////////////////////

    // all outputs one cycle behind pos
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            video <= '0;
        end else begin
            video.de <= in_window;
            video.vs <= frame_start;
            video.hs <= line_sync;
            // border is black
            if (in_window) begin
                video.rgb <= rgb_wide;
            end else begin
                video.rgb <= '0;
            end
        end
    end

endmodule

//--- hdl/i2s_frame_gen.sv
////////////////////////////////////////
// i2s framer
// sclk and lrck from mclk, silent data
////////////////////////////////////////

`timescale 1ns/1ps

`include "av_out_settings.svh"

module i2s_frame_gen (
    input  logic               audgen_mclk,
    input  logic               reset_n,
    output i2s_pkg::i2s_out_t  i2s
);

    import i2s_pkg::*;

    mclk_div_t div_q;
    slot_cnt_t slot_q;
    logic      lrck_q;
    logic      sclk_fall;
    logic      slot_end;

    ////////////////////////////////////////
    // bit clock
    ////////////////////////////////////////

    // counter wraps to 0 here, sclk msb drops
    assign sclk_fall = (div_q == mclk_div_t'(`AV_I2S_MCLK_DIV - 1));

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            div_q <= '0;
        end else begin
            div_q <= div_q + 1'b1;
        end
    end

    ////////////////////////////////////////
    // slot count and channel select
    ////////////////////////////////////////

    // last bit of the current channel
    assign slot_end = (slot_q == slot_cnt_t'(`AV_I2S_SLOT_BITS - 1));

    // one step per sclk period, lrck flips per slot
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            slot_q <= '0;
            lrck_q <= 1'b0;
        end else if (sclk_fall) begin
            slot_q <= slot_q + 1'b1;
            if (slot_end) begin
                lrck_q <= ~lrck_q;
            end
        end
    end

    // no samples yet, dac line stays low
    always_comb begin
        i2s.sclk = div_q[$bits(mclk_div_t)-1];
        i2s.lrck = lrck_q;
        i2s.dac  = 1'b0;
    end

endmodule

//--- hdl/av_out_top.sv
////////////////////////////////////////
// av output top
// raster timer, video stage, i2s framer
////////////////////////////////////////

`timescale 1ns/1ps

module av_out_top (
    input  logic                          audgen_mclk,
    input  logic                          reset_n,
    input  video_timing_pkg::pixel_rgb12_t pixel,
    output video_timing_pkg::video_out_t   video,
    output i2s_pkg::i2s_out_t             i2s,
    output logic                          audio_mclk
);

    import video_timing_pkg::*;

    // current beam position
    raster_pos_t pos;

    ////////////////////////////////////////
    // video
    ////////////////////////////////////////

    raster_timer u_raster_timer (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .pos         (pos)
    );

    // pixel feed is free running
    video_out_stage u_video_out_stage (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .pos         (pos),
        .pixel       (pixel),
        .video       (video)
    );

    ////////////////////////////////////////
    // audio
    ////////////////////////////////////////

    i2s_frame_gen u_i2s_frame_gen (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .i2s         (i2s)
    );

    // dac gets mclk straight through
    assign audio_mclk = audgen_mclk;

endmodule

//--- sim/av_out_tb.sv
////////////////////////////////////////
// av output testbench
// table-driven pixel feed, model counters
// for raster sync, active window and i2s
////////////////////////////////////////

`timescale 1ns/1ps

`include "av_out_settings.svh"

module av_out_tb;

    import video_timing_pkg::*;
    import i2s_pkg::*;

    localparam int table_len    = 16;
    localparam int reset_cycles = 16;
    localparam int frame_cycles = `AV_H_TOTAL * `AV_V_TOTAL;
    // one frame plus reset plus margin
    localparam int max_cycles   = 320000;
    // mclk cycles between lrck edges
    localparam int lrck_half    = `AV_I2S_MCLK_DIV * `AV_I2S_SLOT_BITS;

    logic         audgen_mclk;
    logic         reset_n;
    pixel_rgb12_t pixel;
    video_out_t   video;
    i2s_out_t     i2s;
    logic         audio_mclk;

    // stimulus table and expected rgb per entry
    pixel_rgb12_t stim_pixel [table_len];
    logic [23:0]  stim_rgb [table_len];
    // expected rgb of the last three driven pixels
    logic [23:0]  rgb_hist [3];

    ////////////////////////////////////////
    // model and statistics
    ////////////////////////////////////////

    // position the video outputs decode this cycle
    int          dx;
    int          dy;
    int          div_m;
    int          slot_m;
    logic        lrck_m;
    int          step;
    int          cycle_count = 0;
    int          vs_count;
    int          hs_count;
    int          last_hs;
    int          de_run;
    int          de_lines;
    int          first_de_y;
    int          last_lrck_step;
    logic        lrck_seen;
    video_out_t  exp_video;
    i2s_out_t    exp_i2s;
    logic [11:0] raw;

    av_out_top uut (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .pixel       (pixel),
        .video       (video),
        .i2s         (i2s),
        .audio_mclk  (audio_mclk)
    );

    // 40 ns master clock
    initial begin
        audgen_mclk = 1'b0;
        forever #20 audgen_mclk = ~audgen_mclk;
    end

    // run limit
    always @(posedge audgen_mclk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            fail_and_stop($sformatf("Timeout after %0d cycles, run did not finish", max_cycles));
        end
    end

    // mclk pass-through, looked at mid-phase
    always @(audgen_mclk) begin
        #10;
        check_mclk(audgen_mclk, audio_mclk);
    end

    task automatic fail_and_stop(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_video(input video_out_t expected, input video_out_t actual);
        if (actual !== expected) begin
            fail_and_stop($sformatf(
                "FAIL video expected rgb=%h de=%h vs=%h hs=%h got rgb=%h de=%h vs=%h hs=%h",
                expected.rgb, expected.de, expected.vs, expected.hs,
                actual.rgb, actual.de, actual.vs, actual.hs));
        end
    endtask

    task automatic check_i2s(input i2s_out_t expected, input i2s_out_t actual);
        if (actual !== expected) begin
            fail_and_stop($sformatf(
                "FAIL i2s expected sclk=%h lrck=%h dac=%h got sclk=%h lrck=%h dac=%h",
                expected.sclk, expected.lrck, expected.dac,
                actual.sclk, actual.lrck, actual.dac));
        end
    endtask

    task automatic check_mclk(input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_and_stop($sformatf("FAIL audio_mclk expected %h got %h", expected, actual));
        end
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        if (actual != expected) begin
            fail_and_stop($sformatf("FAIL %s expected %h got %h", what, expected, actual));
        end
    endtask

    // nibble to upper half of its byte
    function automatic logic [23:0] widen_colour(input pixel_rgb12_t p);
        return (24'(p.r) << 20) | (24'(p.g) << 12) | (24'(p.b) << 4);
    endfunction

    initial begin
        reset_n = 1'b0;
        pixel   = '0;
        void'($urandom(12));

        // corners, then random colours
        stim_pixel[0] = 12'h000;
        stim_rgb[0]   = 24'h000000;
        stim_pixel[1] = 12'hFFF;
        stim_rgb[1]   = 24'hF0F0F0;
        stim_pixel[2] = 12'hF00;
        stim_rgb[2]   = 24'hF00000;
        stim_pixel[3] = 12'h0F0;
        stim_rgb[3]   = 24'h00F000;
        stim_pixel[4] = 12'h00F;
        stim_rgb[4]   = 24'h0000F0;
        for (int i = 5; i < table_len; i++) begin
            raw = $urandom();
            stim_pixel[i] = raw;
            stim_rgb[i]   = widen_colour(stim_pixel[i]);
        end
        for (int i = 0; i < 3; i++) begin
            rgb_hist[i] = '0;
        end

        dx = 0;
        dy = 0;
        div_m = 0;
        slot_m = 0;
        lrck_m = 1'b0;
        vs_count = 0;
        hs_count = 0;
        last_hs = 0;
        de_run = 0;
        de_lines = 0;
        first_de_y = -1;
        last_lrck_step = 0;
        lrck_seen = 1'b0;

        // held in reset, all outputs low
        repeat (reset_cycles) begin
            @(posedge audgen_mclk);
            @(negedge audgen_mclk);
            check_video('0, video);
            check_i2s('0, i2s);
        end

        ////////////////////////////////////////
        // one full frame after release
        ////////////////////////////////////////

        for (step = 0; step <= frame_cycles; step++) begin
            @(posedge audgen_mclk);
            if (step == 0) begin
                reset_n <= 1'b1;
            end
            pixel <= stim_pixel[step % table_len];
            rgb_hist[2] = rgb_hist[1];
            rgb_hist[1] = rgb_hist[0];
            rgb_hist[0] = stim_rgb[step % table_len];
            @(negedge audgen_mclk);

            // step 0 is the release edge, still zero
            exp_video = '0;
            if (step > 0) begin
                exp_video.de = (dx >= `AV_H_BPORCH) && (dx < `AV_H_BPORCH + `AV_H_ACTIVE) &&
                               (dy >= `AV_V_BPORCH) && (dy < `AV_V_BPORCH + `AV_V_ACTIVE);
                exp_video.vs = (dx == 0) && (dy == 0);
                exp_video.hs = (dx == `AV_HS_OFFSET);
                if (exp_video.de) begin
                    exp_video.rgb = rgb_hist[2];
                end
            end
            exp_i2s.sclk = (div_m >= `AV_I2S_MCLK_DIV / 2);
            exp_i2s.lrck = lrck_m;
            exp_i2s.dac  = 1'b0;
            check_video(exp_video, video);
            check_i2s(exp_i2s, i2s);

            // sync spacing and window shape from the dut side
            vs_count += video.vs;
            if (video.hs) begin
                if (hs_count > 0) begin
                    check_count("hs spacing", `AV_H_TOTAL, step - last_hs);
                end
                last_hs = step;
                hs_count++;
            end
            de_run += video.de;
            if (step > 0 && dx == `AV_H_TOTAL - 1) begin
                if (de_run != 0) begin
                    check_count("de cycles per line", `AV_H_ACTIVE, de_run);
                    if (de_lines == 0) begin
                        first_de_y = dy;
                    end
                    de_lines++;
                end
                de_run = 0;
            end
            if (i2s.lrck !== lrck_seen) begin
                check_count("lrck spacing", lrck_half, step - last_lrck_step);
                last_lrck_step = step;
                lrck_seen = i2s.lrck;
            end

            // advance the raster model
            if (step > 0) begin
                if (dx == `AV_H_TOTAL - 1) begin
                    dx = 0;
                    dy = (dy == `AV_V_TOTAL - 1) ? 0 : dy + 1;
                end else begin
                    dx++;
                end
            end
            // advance the i2s model, slot steps on sclk fall
            if (div_m == `AV_I2S_MCLK_DIV - 1) begin
                div_m = 0;
                if (slot_m == `AV_I2S_SLOT_BITS - 1) begin
                    slot_m = 0;
                    lrck_m = ~lrck_m;
                end else begin
                    slot_m++;
                end
            end else begin
                div_m++;
            end
        end

        check_count("vs pulses", 1, vs_count);
        check_count("hs pulses", `AV_V_TOTAL, hs_count);
        check_count("de lines", `AV_V_ACTIVE, de_lines);
        check_count("first de line", `AV_V_BPORCH, first_de_y);
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- av_out.f
+incdir+hdl
hdl/video_timing_pkg.sv
hdl/i2s_pkg.sv
hdl/raster_timer.sv
hdl/video_out_stage.sv
hdl/i2s_frame_gen.sv
hdl/av_out_top.sv
sim/av_out_tb.sv

//--- Bender.yml
package:
  name: av_out

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/video_timing_pkg.sv
      - hdl/i2s_pkg.sv
      - hdl/raster_timer.sv
      - hdl/video_out_stage.sv
      - hdl/i2s_frame_gen.sv
      - hdl/av_out_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/av_out_tb.sv
